//--- flist.f
gfx_pix_pkg.sv
gfx_mem_pkg.sv
pix_req_fifo.sv
pix_addr_gen.sv
color_to_memory64.sv
memory_to_color64.sv
mem_cmd_issue.sv
gfx_pix_unit.sv
tb_clk_gen.sv
tb_pix_checker.sv
tb_gfx_pix_unit.sv

//--- Makefile
# Verilator build and run of the pixel access unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_gfx_pix_unit
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_gfx_pix_unit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_gfx_pix_unit;
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  localparam int REQ_DEPTH   = 4;
  localparam int MEM_CREDITS = 2;
  localparam int RD_DEPTH    = 4;
  localparam int WAIT_LIMIT  = 2000; // cycles per wait.

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  logic               req_write;
  logic [COORD_W-1:0] req_x;
  logic [COORD_W-1:0] req_y;
  color_depth_e       req_depth;
  logic [COLOR_W-1:0] req_color;
  logic               req_credit;
  logic [31:0]        base_addr;
  logic [COORD_W-1:0] pitch;
  logic               mem_credit = 1'b0;
  logic               mem_cmd_valid;
  mem_cmd_e           mem_cmd;
  logic [MEM_AW-1:0]  mem_addr;
  logic [MEM_DW-1:0]  mem_wdata;
  logic [MEM_SW-1:0]  mem_sel;
  logic               mem_rvalid = 1'b0;
  logic [MEM_DW-1:0]  mem_rdata  = '0;
  logic               color_valid;
  logic [COLOR_W-1:0] color;
  int                 err_cnt;
  int                 check_cnt;
  int                 pending;

  logic [31:0] rng = 32'd92954;
  int          credits;                 // client credits in hand.
  bit          hung;
  int          local_err  = 0;
  int          errs_before;
  int          tests_run  = 0;
  int          tests_fail = 0;
  int          x_span;
  int          y_span;
  int          crd_min;
  int          crd_span;
  int          rd_min;
  int          rd_span;
  int          rd_peak    = 0;          // most reads at the memory, this test.
  int          cyc        = 0;
  logic [63:0] mem_words [logic [28:0]]; // sparse memory.
  logic [63:0] rd_data_q [$];
  int          rd_due_q  [$];
  int          crd_due_q [$];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gfx_pix_unit #(
    .REQ_DEPTH   (REQ_DEPTH),
    .MEM_CREDITS (MEM_CREDITS),
    .RD_DEPTH    (RD_DEPTH)
  ) dut_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .req_write_i     (req_write),
    .req_x_i         (req_x),
    .req_y_i         (req_y),
    .req_depth_i     (req_depth),
    .req_color_i     (req_color),
    .req_credit_o    (req_credit),
    .base_addr_i     (base_addr),
    .pitch_i         (pitch),
    .mem_credit_i    (mem_credit),
    .mem_cmd_valid_o (mem_cmd_valid),
    .mem_cmd_o       (mem_cmd),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_sel_o       (mem_sel),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata),
    .color_valid_o   (color_valid),
    .color_o         (color)
  );

  tb_pix_checker #(
    .MEM_CREDITS (MEM_CREDITS),
    .RD_DEPTH    (RD_DEPTH)
  ) u_checker (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .req_write_i     (req_write),
    .req_x_i         (req_x),
    .req_y_i         (req_y),
    .req_depth_i     (req_depth),
    .req_color_i     (req_color),
    .base_addr_i     (base_addr),
    .pitch_i         (pitch),
    .mem_credit_i    (mem_credit),
    .mem_cmd_valid_i (mem_cmd_valid),
    .mem_cmd_i       (mem_cmd),
    .mem_addr_i      (mem_addr),
    .mem_wdata_i     (mem_wdata),
    .mem_sel_i       (mem_sel),
    .mem_rvalid_i    (mem_rvalid),
    .color_valid_i   (color_valid),
    .color_i         (color),
    .err_cnt_o       (err_cnt),
    .check_cnt_o     (check_cnt),
    .pending_o       (pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int pick(input int n); // 0 to n-1.
    rng = xorshift32(rng);
    return int'(rng % 32'(n));
  endfunction

  function automatic logic [63:0] fill_word(input logic [28:0] addr);
    return {3'b101, addr, ~{3'b101, addr}};
  endfunction

  always @(posedge clk) begin
    if (req_credit) credits++;
  end

  // memory model. data is taken when the read is issued.
  always @(posedge clk) begin
    logic [63:0] w;
    cyc++;
    if (rst_n && mem_cmd_valid) begin
      w = mem_words.exists(mem_addr) ? mem_words[mem_addr] : fill_word(mem_addr);
      if (mem_cmd == CMD_WRITE) begin
        for (int i = 0; i < 8; i++) begin
          if (mem_sel[i]) w[8*i +: 8] = mem_wdata[8*i +: 8];
        end
        mem_words[mem_addr] = w;
      end else begin
        rd_data_q.push_back(w);
        rd_due_q.push_back(cyc + rd_min + pick(rd_span));
        if (rd_due_q.size() > rd_peak) rd_peak = rd_due_q.size(); // reads not yet answered.
      end
      crd_due_q.push_back(cyc + crd_min + pick(crd_span));
    end
    #2;
    mem_rvalid = 1'b0;
    mem_credit = 1'b0;
    if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin // in order.
      void'(rd_due_q.pop_front());
      mem_rdata  = rd_data_q.pop_front();
      mem_rvalid = 1'b1;
    end
    if (crd_due_q.size() != 0 && crd_due_q[0] <= cyc) begin
      void'(crd_due_q.pop_front());
      mem_credit = 1'b1;                 // one credit per cycle.
    end
  end

  task automatic set_mem_timing(input int cmin, input int cspan, input int rmin,
                                input int rspan);
    crd_min  = cmin;
    crd_span = cspan;
    rd_min   = rmin;
    rd_span  = rspan;
  endtask

  task automatic send_req(input bit wr, input int max_gap);
    int n;
    int gap;
    n = 0;
    while (credits == 0 && !hung) begin
      if (n == WAIT_LIMIT) begin
        $display("client got no request credit back within %0d cycles", WAIT_LIMIT);
        hung = 1'b1;
      end
      n++;
      @(posedge clk);
      #2;
    end
    if (!hung) begin
      req_valid = 1'b1;
      req_write = wr;
      req_x     = COORD_W'(pick(x_span));
      req_y     = COORD_W'(pick(y_span));
      case (pick(3))
        0:       req_depth = DEPTH_8;
        1:       req_depth = DEPTH_16;
        default: req_depth = DEPTH_32;
      endcase
      rng       = xorshift32(rng);
      req_color = rng;                   // upper bits must be dropped by the unit.
      credits--;
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      gap = pick(max_gap + 1);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!hung && !(credits == REQ_DEPTH && pending == 0 &&
                      rd_due_q.size() == 0 && crd_due_q.size() == 0)) begin
      if (n == WAIT_LIMIT) begin
        $display("unit did not drain, %0d client credits back and %0d results pending",
                 credits, pending);
        hung = 1'b1;
      end
      n++;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic start_test(input int xs, input int ys);
    errs_before = err_cnt + local_err;
    x_span      = xs;
    y_span      = ys;
    rd_peak     = 0;
    rng         = xorshift32(rng);
    base_addr   = rng & 32'h00ff_fff8;   // word aligned.
    pitch       = COORD_W'(128 + 8 * pick(16));
  endtask

  task automatic end_test(input string name);
    int n;
    wait_idle();
    n = err_cnt + local_err - errs_before;
    tests_run++;
    if (hung || n != 0) tests_fail++;
    if (hung) $display("test %s stopped early, the unit hung", name);
    else $display("test %s done, %0d errors", name, n);
  endtask

  initial begin
    int n;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_x     = '0;
    req_y     = '0;
    req_depth = DEPTH_8;
    req_color = '0;
    base_addr = '0;
    pitch     = COORD_W'(128);
    credits   = REQ_DEPTH;
    hung      = 1'b0;
    set_mem_timing(1, 6, 1, 4);
    n = 0;
    while (!rst_n && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      hung = 1'b1;
    end
    @(posedge clk);
    #2;

    start_test(1024, 64);                // addressing and lane placement.
    for (int i = 0; i < 40; i++) send_req(1'b1, 3);
    end_test("write_addressing");

    start_test(8, 4);                    // small area so reads hit writes.
    for (int i = 0; i < 60; i++) send_req(pick(2) == 0, 2);
    end_test("read_back");

    set_mem_timing(20, 20, 1, 4);        // memory hoards its credits.
    start_test(8, 4);
    for (int i = 0; i < 24; i++) send_req(pick(2) == 0, 0);
    end_test("credit_starvation");

    set_mem_timing(1, 1, 6, 3);
    start_test(16, 2);
    for (int i = 0; i < 16; i++) send_req(1'b1, 0);
    for (int i = 0; i < 16; i++) send_req(1'b0, 0);
    wait_idle();
    if (!hung && rd_peak != RD_DEPTH) begin
      local_err++;
      $display("read burst reached %0d reads in flight, tracker holds %0d", rd_peak, RD_DEPTH);
    end
    end_test("read_burst");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_fail, check_cnt, err_cnt + local_err);
    if (!hung && tests_fail == 0 && err_cnt + local_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_pix_checker.sv
`default_nettype none
`timescale 1ns/1ns

module tb_pix_checker #(
  parameter int MEM_CREDITS = 2,
  parameter int RD_DEPTH    = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_valid_i,
  input  logic                             req_write_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_x_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_y_i,
  input  logic [2:0]                       req_depth_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]  req_color_i,
  input  logic [31:0]                      base_addr_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  pitch_i,
  input  logic                             mem_credit_i,
  input  logic                             mem_cmd_valid_i,
  input  logic                             mem_cmd_i,
  input  logic [gfx_mem_pkg::MEM_AW-1:0]   mem_addr_i,
  input  logic [gfx_mem_pkg::MEM_DW-1:0]   mem_wdata_i,
  input  logic [gfx_mem_pkg::MEM_SW-1:0]   mem_sel_i,
  input  logic                             mem_rvalid_i,
  input  logic                             color_valid_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]  color_i,
  output int                               err_cnt_o,
  output int                               check_cnt_o,
  output int                               pending_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  typedef struct packed {
    logic        write;
    logic [28:0] addr;
    logic [63:0] data;
    logic [7:0]  sel;
    logic [2:0]  lsb;
    logic [2:0]  bpp;
  } exp_cmd_t;

  exp_cmd_t    exp_q   [$];            // commands still to come, in request order.
  logic [31:0] color_q [$];            // colours still to come.
  logic [63:0] shadow  [logic [28:0]];
  int          errs      = 0;
  int          checks    = 0;
  int          pending   = 0;
  int          issued    = 0;
  int          refunded  = 0;
  int          in_flight = 0;
  logic        rvalid_q  = 1'b0;

  assign err_cnt_o   = errs;
  assign check_cnt_o = checks;
  assign pending_o   = pending;

  // untouched words read back as a pattern of their own address.
  function automatic logic [63:0] fill_word(input logic [28:0] addr);
    return {3'b101, addr, ~{3'b101, addr}};
  endfunction

  function automatic int bytes_of(input logic [2:0] code);
    case (code)
      DEPTH_8:  return 1;
      DEPTH_16: return 2;
      DEPTH_32: return 4;
      default:  return 0;
    endcase
  endfunction

  function automatic logic [31:0] mask_of(input int bpp);
    if (bpp >= 4) return 32'hffff_ffff;
    return (32'd1 << (8 * bpp)) - 32'd1;
  endfunction

  task automatic report_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    errs++;
    $display("FAILED t=%0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic report_plain(input string msg);
    errs++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  always @(posedge clk_i) begin
    exp_cmd_t    e;
    logic [31:0] byte_addr;
    logic [31:0] c;
    logic [63:0] w;
    logic [7:0]  lanes;
    int          bpp;
    if (rst_n_i) begin
      if (color_valid_i != rvalid_q) begin
        report_plain("colour valid did not follow read data by one cycle");
      end
      rvalid_q = mem_rvalid_i;
      if (color_valid_i) begin
        if (color_q.size() == 0) begin
          report_plain("colour returned with no read outstanding");
        end else begin
          c = color_q.pop_front();
          checks++;
          if (color_i !== c) report_value("read colour", 64'(color_i), 64'(c));
        end
      end
      if (mem_rvalid_i) in_flight--;
      if (mem_cmd_valid_i) begin
        issued++;
        if (issued > MEM_CREDITS + refunded) begin
          report_plain("memory command issued without a memory credit");
        end
        if (exp_q.size() == 0) begin
          report_plain("memory command with no request behind it");
        end else begin
          e = exp_q.pop_front();
          checks++;
          if (mem_cmd_i !== e.write) report_value("command", 64'(mem_cmd_i), 64'(e.write));
          if (mem_addr_i !== e.addr) report_value("word address", 64'(mem_addr_i), 64'(e.addr));
          if (mem_sel_i !== e.sel) report_value("byte selects", 64'(mem_sel_i), 64'(e.sel));
          w = shadow.exists(e.addr) ? shadow[e.addr] : fill_word(e.addr);
          if (e.write) begin
            if (mem_wdata_i !== e.data) report_value("write data", mem_wdata_i, e.data);
            for (int i = 0; i < 8; i++) begin
              if (e.sel[i]) w[8*i +: 8] = e.data[8*i +: 8];
            end
            shadow[e.addr] = w;
          end else begin
            in_flight++;
            if (in_flight > RD_DEPTH) report_plain("more reads in flight than the tracker holds");
            c = 32'(w >> (8 * int'(e.lsb))) & mask_of(int'(e.bpp)); // zero extended.
            color_q.push_back(c);
          end
        end
      end
      if (mem_credit_i) refunded++;     // counts from the next command on.
      if (req_valid_i) begin
        bpp       = bytes_of(req_depth_i);
        byte_addr = base_addr_i + 32'(req_y_i) * 32'(pitch_i) + 32'(req_x_i) * 32'(bpp);
        lanes     = 8'((32'd1 << bpp) - 32'd1);
        c         = req_color_i & mask_of(bpp);
        e.write   = req_write_i;
        e.addr    = byte_addr[31:3];
        e.lsb     = byte_addr[2:0];
        e.bpp     = 3'(bpp);
        e.data    = req_write_i ? 64'(c) << (8 * int'(byte_addr[2:0])) : '0;
        e.sel     = req_write_i ? lanes << byte_addr[2:0] : 8'hff; // reads take all lanes.
        exp_q.push_back(e);
      end
      pending = exp_q.size() + color_q.size();
    end
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o; // free running.
  end

  // reset drops off just after an edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- gfx_pix_unit.sv
`default_nettype none
`timescale 1ns/1ns

module gfx_pix_unit #(
  parameter int REQ_DEPTH   = 4,
  parameter int MEM_CREDITS = 2,
  parameter int RD_DEPTH    = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_valid_i,
  input  logic                             req_write_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_x_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_y_i,
  input  gfx_pix_pkg::color_depth_e        req_depth_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]  req_color_i,
  output logic                             req_credit_o,
  input  logic [gfx_mem_pkg::MEM_AW+2:0]   base_addr_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  pitch_i,
  input  logic                             mem_credit_i,
  output logic                             mem_cmd_valid_o,
  output gfx_mem_pkg::mem_cmd_e            mem_cmd_o,
  output logic [gfx_mem_pkg::MEM_AW-1:0]   mem_addr_o,
  output logic [gfx_mem_pkg::MEM_DW-1:0]   mem_wdata_o,
  output logic [gfx_mem_pkg::MEM_SW-1:0]   mem_sel_o,
  input  logic                             mem_rvalid_i,
  input  logic [gfx_mem_pkg::MEM_DW-1:0]   mem_rdata_i,
  output logic                             color_valid_o,
  output logic [gfx_pix_pkg::COLOR_W-1:0]  color_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  // fifo head.
  logic               head_valid;
  logic               head_write;
  logic [COORD_W-1:0] head_x;
  logic [COORD_W-1:0] head_y;
  color_depth_e       head_depth;
  logic [COLOR_W-1:0] head_color;
  logic               head_pop;

  // address stage.
  logic               ag_valid;
  logic               ag_write;
  color_depth_e       ag_depth;
  logic [COLOR_W-1:0] ag_color;
  logic [MEM_AW-1:0]  ag_waddr;
  logic [2:0]         ag_lsb;
  logic               ag_ready;

  // lane placement for writes.
  logic [MEM_DW-1:0]  wr_data;
  logic [MEM_SW-1:0]  wr_sel;

  pix_req_fifo #(
    .REQ_DEPTH (REQ_DEPTH)
  ) u_req_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_x_i      (req_x_i),
    .req_y_i      (req_y_i),
    .req_depth_i  (req_depth_i),
    .req_color_i  (req_color_i),
    .pop_i        (head_pop),
    .req_credit_o (req_credit_o),
    .head_valid_o (head_valid),
    .head_write_o (head_write),
    .head_x_o     (head_x),
    .head_y_o     (head_y),
    .head_depth_o (head_depth),
    .head_color_o (head_color)
  );

  pix_addr_gen u_addr_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (head_valid),
    .in_write_i  (head_write),
    .in_x_i      (head_x),
    .in_y_i      (head_y),
    .in_depth_i  (head_depth),
    .in_color_i  (head_color),
    .base_addr_i (base_addr_i),
    .pitch_i     (pitch_i),
    .out_ready_i (ag_ready),
    .pop_o       (head_pop),
    .out_valid_o (ag_valid),
    .out_write_o (ag_write),
    .out_depth_o (ag_depth),
    .out_color_o (ag_color),
    .out_waddr_o (ag_waddr),
    .out_lsb_o   (ag_lsb)
  );

  color_to_memory64 u_place (
    .color_depth_i (ag_depth),
    .color_i       (ag_color),
    .x_lsb_i       (ag_lsb),
    .mem_o         (wr_data),
    .sel_o         (wr_sel)
  );

  mem_cmd_issue #(
    .MEM_CREDITS (MEM_CREDITS),
    .RD_DEPTH    (RD_DEPTH)
  ) u_cmd_issue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (ag_valid),
    .in_write_i      (ag_write),
    .in_depth_i      (ag_depth),
    .in_waddr_i      (ag_waddr),
    .in_wdata_i      (wr_data),
    .in_sel_i        (wr_sel),
    .in_lsb_i        (ag_lsb),
    .in_ready_o      (ag_ready),
    .mem_credit_i    (mem_credit_i),
    .mem_cmd_valid_o (mem_cmd_valid_o),
    .mem_cmd_o       (mem_cmd_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_sel_o       (mem_sel_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .color_valid_o   (color_valid_o),
    .color_o         (color_o)
  );

endmodule

`default_nettype wire

//--- mem_cmd_issue.sv
`default_nettype none
`timescale 1ns/1ns

module mem_cmd_issue #(
  parameter int MEM_CREDITS = 2,
  parameter int RD_DEPTH    = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             in_valid_i,
  input  logic                             in_write_i,
  input  gfx_pix_pkg::color_depth_e        in_depth_i,
  input  logic [gfx_mem_pkg::MEM_AW-1:0]   in_waddr_i,
  input  logic [gfx_mem_pkg::MEM_DW-1:0]   in_wdata_i,
  input  logic [gfx_mem_pkg::MEM_SW-1:0]   in_sel_i,
  input  logic [2:0]                       in_lsb_i,
  output logic                             in_ready_o,
  input  logic                             mem_credit_i,
  output logic                             mem_cmd_valid_o,
  output gfx_mem_pkg::mem_cmd_e            mem_cmd_o,
  output logic [gfx_mem_pkg::MEM_AW-1:0]   mem_addr_o,
  output logic [gfx_mem_pkg::MEM_DW-1:0]   mem_wdata_o,
  output logic [gfx_mem_pkg::MEM_SW-1:0]   mem_sel_o,
  input  logic                             mem_rvalid_i,
  input  logic [gfx_mem_pkg::MEM_DW-1:0]   mem_rdata_i,
  output logic                             color_valid_o,
  output logic [gfx_pix_pkg::COLOR_W-1:0]  color_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  localparam int CRD_W = $clog2(MEM_CREDITS + 1);
  localparam int PTR_W = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
  localparam int CNT_W = $clog2(RD_DEPTH + 1);

  logic [CRD_W-1:0]   credit_q;              // commands memory still takes.
  logic               issue;
  logic               rd_push;
  logic               rd_pop;
  logic               rd_full;
  logic [PTR_W-1:0]   trk_wr_q;
  logic [PTR_W-1:0]   trk_rd_q;
  logic [CNT_W-1:0]   trk_cnt_q;             // reads in flight.
  color_depth_e       trk_depth_q [RD_DEPTH];
  logic [2:0]         trk_lsb_q   [RD_DEPTH];
  logic [COLOR_W-1:0] rd_color;

  assign rd_full    = (trk_cnt_q == CNT_W'(RD_DEPTH));
  assign in_ready_o = (credit_q != '0) & (in_write_i | ~rd_full);
  assign issue      = in_valid_i & in_ready_o;
  assign rd_push    = issue & ~in_write_i;
  assign rd_pop     = mem_rvalid_i & (trk_cnt_q != '0);

  // command leaves in the same cycle the stage holds it.
  assign mem_cmd_valid_o = issue;
  assign mem_cmd_o       = in_write_i ? CMD_WRITE : CMD_READ;
  assign mem_addr_o      = in_waddr_i;
  assign mem_wdata_o     = in_wdata_i;
  assign mem_sel_o       = in_write_i ? in_sel_i : '1; // reads fetch the whole word.

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CRD_W'(MEM_CREDITS);
    end else begin
      case ({issue, mem_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;                  // spend and refund cancel.
      endcase
    end
  end

  // lane info of each read, replayed when its data comes back in order.
  always_ff @(posedge clk_i) begin
    if (rd_push) begin
      trk_depth_q[trk_wr_q] <= in_depth_i;
      trk_lsb_q[trk_wr_q]   <= in_lsb_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trk_wr_q  <= '0;
      trk_rd_q  <= '0;
      trk_cnt_q <= '0;
    end else begin
      if (rd_push) begin
        trk_wr_q <= (trk_wr_q == PTR_W'(RD_DEPTH - 1)) ? '0 : trk_wr_q + 1'b1;
      end
      if (rd_pop) begin
        trk_rd_q <= (trk_rd_q == PTR_W'(RD_DEPTH - 1)) ? '0 : trk_rd_q + 1'b1;
      end
      case ({rd_push, rd_pop})
        2'b10:   trk_cnt_q <= trk_cnt_q + 1'b1;
        2'b01:   trk_cnt_q <= trk_cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  memory_to_color64 u_extract (
    .color_depth_i (trk_depth_q[trk_rd_q]),
    .mem_i         (mem_rdata_i),
    .mem_lsb_i     (trk_lsb_q[trk_rd_q]),
    .color_o       (rd_color)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      color_valid_o <= 1'b0;
    end else begin
      color_valid_o <= rd_pop;      // one cycle after rvalid.
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_pop) begin
      color_o <= rd_color;
    end
  end

endmodule

`default_nettype wire

//--- memory_to_color64.sv
`default_nettype none
`timescale 1ns/1ns

module memory_to_color64 (
  input  gfx_pix_pkg::color_depth_e        color_depth_i,
  input  logic [gfx_mem_pkg::MEM_DW-1:0]   mem_i,
  input  logic [2:0]                       mem_lsb_i,
  output logic [gfx_pix_pkg::COLOR_W-1:0]  color_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  mem_word_u  word;
  logic [2:0] lane;

  assign word = mem_i;
  assign lane = pix_lane(color_depth_i, mem_lsb_i);

  // zero extended up to the colour width.
  always_comb begin
    color_o = '0;
    case (color_depth_i)
      DEPTH_8: begin
        color_o[7:0] = word.bytes[lane];
      end
      DEPTH_16: begin
        color_o[15:0] = {word.bytes[lane + 3'd1], word.bytes[lane]};
      end
      DEPTH_32: begin
        color_o = word.halves[lane[2]];
      end
      default: ;                        // unknown code reads as zero.
    endcase
  end

endmodule

`default_nettype wire

//--- color_to_memory64.sv
`default_nettype none
`timescale 1ns/1ns

module color_to_memory64 (
  input  gfx_pix_pkg::color_depth_e        color_depth_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]  color_i,
  input  logic [2:0]                       x_lsb_i,
  output logic [gfx_mem_pkg::MEM_DW-1:0]   mem_o,
  output logic [gfx_mem_pkg::MEM_SW-1:0]   sel_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  mem_word_u  word;
  logic [2:0] lane;

  assign lane = pix_lane(color_depth_i, x_lsb_i); // aligned first byte.

  // only the pixel's own colour bits land in the word.
  // bits above the pixel width drop out here.
  always_comb begin
    word  = '0;
    sel_o = '0;
    case (color_depth_i)
      DEPTH_8: begin
        word.bytes[lane] = color_i[7:0];
        sel_o[lane]      = 1'b1;
      end
      DEPTH_16: begin
        word.bytes[lane]        = color_i[7:0];  // low byte first.
        word.bytes[lane + 3'd1] = color_i[15:8];
        sel_o[lane +: 2]        = 2'b11;         // aligned pair.
      end
      DEPTH_32: begin
        word.halves[lane[2]] = color_i;          // whole half.
        sel_o[lane +: 4]     = 4'hF;
      end
      default: ;                                 // unknown code, no lanes.
    endcase
  end

  assign mem_o = word;

endmodule

`default_nettype wire

//--- pix_addr_gen.sv
`default_nettype none
`timescale 1ns/1ns

module pix_addr_gen (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              in_valid_i,
  input  logic                              in_write_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]   in_x_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]   in_y_i,
  input  gfx_pix_pkg::color_depth_e         in_depth_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]   in_color_i,
  input  logic [gfx_mem_pkg::MEM_AW+2:0]    base_addr_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]   pitch_i,
  input  logic                              out_ready_i,
  output logic                              pop_o,
  output logic                              out_valid_o,
  output logic                              out_write_o,
  output gfx_pix_pkg::color_depth_e         out_depth_o,
  output logic [gfx_pix_pkg::COLOR_W-1:0]   out_color_o,
  output logic [gfx_mem_pkg::MEM_AW-1:0]    out_waddr_o,
  output logic [2:0]                        out_lsb_o
);
  import gfx_pix_pkg::*;
  import gfx_mem_pkg::*;

  localparam int ADDR_W = MEM_AW + 3; // byte address.

  logic              take;
  logic [ADDR_W-1:0] row_off;
  logic [ADDR_W-1:0] col_off;
  logic [ADDR_W-1:0] byte_addr;

  // stage is free when empty or when its command leaves this cycle.
  assign take  = ~out_valid_o | out_ready_i;
  assign pop_o = in_valid_i & take;

  assign row_off   = ADDR_W'(in_y_i) * ADDR_W'(pitch_i);                 // y * pitch.
  assign col_off   = ADDR_W'(in_x_i) * ADDR_W'(depth_bytes(in_depth_i)); // x * bpp.
  assign byte_addr = base_addr_i + row_off + col_off;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (take) begin
      out_valid_o <= in_valid_i;
    end
  end

  // pixel never crosses a word, so word and lane split cleanly.
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      out_write_o <= in_write_i;
      out_depth_o <= in_depth_i;
      out_color_o <= in_color_i;
      out_waddr_o <= byte_addr[ADDR_W-1:3]; // word address.
      out_lsb_o   <= byte_addr[2:0];        // byte inside word.
    end
  end

endmodule

`default_nettype wire

//--- pix_req_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module pix_req_fifo #(
  parameter int REQ_DEPTH = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_valid_i,
  input  logic                             req_write_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_x_i,
  input  logic [gfx_pix_pkg::COORD_W-1:0]  req_y_i,
  input  gfx_pix_pkg::color_depth_e        req_depth_i,
  input  logic [gfx_pix_pkg::COLOR_W-1:0]  req_color_i,
  input  logic                             pop_i,
  output logic                             req_credit_o,
  output logic                             head_valid_o,
  output logic                             head_write_o,
  output logic [gfx_pix_pkg::COORD_W-1:0]  head_x_o,
  output logic [gfx_pix_pkg::COORD_W-1:0]  head_y_o,
  output gfx_pix_pkg::color_depth_e        head_depth_o,
  output logic [gfx_pix_pkg::COLOR_W-1:0]  head_color_o
);
  import gfx_pix_pkg::*;

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  logic [REQ_DEPTH-1:0] write_q;              // op per slot.
  logic [COORD_W-1:0]   x_q     [REQ_DEPTH];
  logic [COORD_W-1:0]   y_q     [REQ_DEPTH];
  color_depth_e         depth_q [REQ_DEPTH];
  logic [COLOR_W-1:0]   color_q [REQ_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 push;
  logic                 pop;

  assign push = req_valid_i;          // client holds a credit, so never full.
  assign pop  = pop_i & head_valid_o;

  assign head_valid_o = (cnt_q != '0);
  assign head_write_o = write_q[rd_ptr_q];
  assign head_x_o     = x_q[rd_ptr_q];
  assign head_y_o     = y_q[rd_ptr_q];
  assign head_depth_o = depth_q[rd_ptr_q];
  assign head_color_o = color_q[rd_ptr_q];
  assign req_credit_o = pop;          // slot freed, credit back to client.

  always_ff @(posedge clk_i) begin
    if (push) begin
      write_q[wr_ptr_q] <= req_write_i;
      x_q[wr_ptr_q]     <= req_x_i;
      y_q[wr_ptr_q]     <= req_y_i;
      depth_q[wr_ptr_q] <= req_depth_i;
      color_q[wr_ptr_q] <= req_color_i;
    end
  end

  // ring pointers wrap at REQ_DEPTH, not at a power of two.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;                      // both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

//--- gfx_mem_pkg.sv
`default_nettype none

package gfx_mem_pkg;

  localparam int MEM_DW = 64; // data bus.
  localparam int MEM_SW = 8;  // one select per byte.
  localparam int MEM_AW = 29; // word address, 32-bit byte space.

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } mem_cmd_e;

  // one bus word, seen as byte lanes or as 32-bit halves.
  typedef union packed {
    logic [MEM_SW-1:0][7:0] bytes;
    logic [1:0][31:0]       halves;
  } mem_word_u;

endpackage

`default_nettype wire

//--- gfx_pix_pkg.sv
`default_nettype none

package gfx_pix_pkg;

  // depth code is bits per pixel over four, minus one.
  typedef enum logic [2:0] {
    DEPTH_8  = 3'd1,
    DEPTH_16 = 3'd3,
    DEPTH_32 = 3'd7
  } color_depth_e;

  localparam int COLOR_W = 32; // client colour word.
  localparam int COORD_W = 16; // x and y.

  // bytes per pixel, zero for an unknown code.
  function automatic logic [2:0] depth_bytes(color_depth_e depth);
    case (depth)
      DEPTH_8:  return 3'd1;
      DEPTH_16: return 3'd2;
      DEPTH_32: return 3'd4;
      default:  return 3'd0;
    endcase
  endfunction

  // first byte lane of a pixel inside its word.
  // low bits are cleared to the pixel size so lanes stay aligned.
  function automatic logic [2:0] pix_lane(color_depth_e depth, logic [2:0] lsb);
    logic [2:0] code;
    code = depth;
    return lsb & ~{1'b0, code[2:1]}; // code[2:1] is bytes minus one.
  endfunction

endpackage

`default_nettype wire
